/* vcortex_pkg.sv */
// vcortex shared definitions
// scaled video timing, local bus map, widths and display state encoding
package vcortex_pkg;

    //////////////////////////////////////////////////
    // video timing
    //////////////////////////////////////////////////
    localparam int hvalid_w = 16;                       // visible pixels per line
    localparam int hfp_w    = 2;                        // front porch
    localparam int hsync_w  = 4;                        // sync pulse
    localparam int hbp_w    = 3;                        // back porch
    localparam int htotal_w = hvalid_w + hfp_w + hsync_w + hbp_w;

    localparam int vvalid_w = 8;                        // in lines
    localparam int vfp_w    = 1;
    localparam int vsync_w  = 2;
    localparam int vbp_w    = 2;
    localparam int vtotal_w = vvalid_w + vfp_w + vsync_w + vbp_w;

    localparam int h_cnt_w     = 5;
    localparam int v_cnt_w     = 4;
    localparam int lb_data_w   = 32;
    localparam int lb_addr_w   = 12;
    localparam int sram_addr_w = 18;
    localparam int sram_data_w = 16;
    localparam int vga_res_w   = 4;                     // bits per colour
    localparam int bg_w        = 3 * vga_res_w;         // packed rgb, red on top
    localparam int frm_cnt_w   = 16;

    typedef logic [h_cnt_w-1:0]     h_cnt_t;
    typedef logic [v_cnt_w-1:0]     v_cnt_t;
    typedef logic [sram_addr_w-1:0] sram_addr_t;

    // counter decode points, end values exclusive
    localparam h_cnt_t h_last     = h_cnt_t'(htotal_w - 1);
    localparam h_cnt_t h_vis_end  = h_cnt_t'(hvalid_w);
    localparam h_cnt_t h_sync_beg = h_cnt_t'(hvalid_w + hfp_w);
    localparam h_cnt_t h_sync_end = h_cnt_t'(hvalid_w + hfp_w + hsync_w);
    localparam v_cnt_t v_last     = v_cnt_t'(vtotal_w - 1);
    localparam v_cnt_t v_vis_end  = v_cnt_t'(vvalid_w);
    localparam v_cnt_t v_sync_beg = v_cnt_t'(vvalid_w + vfp_w);
    localparam v_cnt_t v_sync_end = v_cnt_t'(vvalid_w + vfp_w + vsync_w);
    localparam sram_addr_t line_stride = sram_addr_t'(hvalid_w);  // words per line

    // local bus register map
    localparam logic [lb_addr_w-1:0] reg_ctrl   = 12'h000;  // bit 0 enable
    localparam logic [lb_addr_w-1:0] reg_base   = 12'h004;  // frame buffer base
    localparam logic [lb_addr_w-1:0] reg_bg     = 12'h008;  // background colour
    localparam logic [lb_addr_w-1:0] reg_status = 12'h00C;  // read only

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_FRAME,
        ST_ACTIVE,
        ST_DRAIN
    } disp_state_t;

endpackage

/* vga_sync_gen.sv */
// vga sync generator
// free running h/v counters with registered sync, visible and frame decode,
// every decode lines up with the counter value it belongs to
`timescale 1ns/1ps

module vga_sync_gen
(
    input  logic                            sys_clk_50,
    input  logic                            rst,
    output logic [vcortex_pkg::h_cnt_w-1:0] h_cnt,
    output logic [vcortex_pkg::v_cnt_w-1:0] v_cnt,
    output logic                            hsync_raw_n,
    output logic                            vsync_raw_n,
    output logic                            visible,
    output logic                            frame_start,
    output logic                            frame_end
);

    logic [vcortex_pkg::h_cnt_w-1:0] h_nxt;     // count for next cycle
    logic [vcortex_pkg::v_cnt_w-1:0] v_nxt;

    //////////////////////////////////////////////////
    // next count
    //////////////////////////////////////////////////
    always_comb
    begin
        h_nxt = h_cnt + 1'b1;
        v_nxt = v_cnt;
        if (h_cnt == vcortex_pkg::h_last)           // line end
        begin
            h_nxt = '0;
            if (v_cnt == vcortex_pkg::v_last)       // frame end
                v_nxt = '0;
            else
                v_nxt = v_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // counters and decode, decoded from next count
    //////////////////////////////////////////////////
    always_ff @(posedge sys_clk_50)
    begin
        if (rst)
        begin
            h_cnt       <= '0;
            v_cnt       <= '0;
            hsync_raw_n <= 1'b1;                    // inactive
            vsync_raw_n <= 1'b1;
            visible     <= 1'b1;                    // count (0,0) is a visible pixel
            frame_start <= 1'b0;
            frame_end   <= 1'b0;
        end
        else
        begin
            h_cnt       <= h_nxt;
            v_cnt       <= v_nxt;
            hsync_raw_n <= !((h_nxt >= vcortex_pkg::h_sync_beg) &&
                             (h_nxt <  vcortex_pkg::h_sync_end));
            vsync_raw_n <= !((v_nxt >= vcortex_pkg::v_sync_beg) &&
                             (v_nxt <  vcortex_pkg::v_sync_end));
            visible     <= (h_nxt < vcortex_pkg::h_vis_end) &&
                           (v_nxt < vcortex_pkg::v_vis_end);
            frame_start <= (h_nxt == '0) && (v_nxt == '0);
            frame_end   <= (h_nxt == vcortex_pkg::h_last) &&
                           (v_nxt == vcortex_pkg::v_last);
        end
    end

endmodule

/* vcortex_ctrl_fsm.sv */
// display controller FSM
// gates pixel fetching so that it always covers whole frames,
// starting on a frame start and stopping only on a frame end
`timescale 1ns/1ps

module vcortex_ctrl_fsm
(
    input  logic                      sys_clk_50,
    input  logic                      rst,
    input  logic                      disp_enable,
    input  logic                      frame_start,
    input  logic                      frame_end,
    output logic                      fetch_en,
    output logic                      frame_done,
    output vcortex_pkg::disp_state_t  disp_state
);

    vcortex_pkg::disp_state_t nxt_state;
    logic                     running;              // active or draining

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////
    always_comb
    begin
        nxt_state = disp_state;
        case (disp_state)
            vcortex_pkg::ST_IDLE:
            begin
                if (disp_enable)
                    nxt_state = vcortex_pkg::ST_WAIT_FRAME;
            end
            vcortex_pkg::ST_WAIT_FRAME:
            begin
                if (!disp_enable)                   // dropped before any fetch
                    nxt_state = vcortex_pkg::ST_IDLE;
                else if (frame_start)
                    nxt_state = vcortex_pkg::ST_ACTIVE;
            end
            vcortex_pkg::ST_ACTIVE:
            begin
                if (!disp_enable && frame_end)      // already on the boundary
                    nxt_state = vcortex_pkg::ST_IDLE;
                else if (!disp_enable)
                    nxt_state = vcortex_pkg::ST_DRAIN;
            end
            vcortex_pkg::ST_DRAIN:
            begin
                if (frame_end)
                    nxt_state = vcortex_pkg::ST_IDLE;
            end
            default: nxt_state = vcortex_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge sys_clk_50)
    begin
        if (rst)
            disp_state <= vcortex_pkg::ST_IDLE;
        else
            disp_state <= nxt_state;
    end

    assign running    = (disp_state == vcortex_pkg::ST_ACTIVE) ||
                        (disp_state == vcortex_pkg::ST_DRAIN);
    // fetch from the frame start cycle itself, pixel (0,0)
    assign fetch_en   = running ||
                        ((disp_state == vcortex_pkg::ST_WAIT_FRAME) && frame_start);
    assign frame_done = running && frame_end;       // one per displayed frame

endmodule

/* lb_regs.sv */
// local bus register file
// control, frame buffer base, background colour and status with frame count,
// fixed one cycle latency on both read and write
`timescale 1ns/1ps

module lb_regs
(
    input  logic                                sys_clk_50,
    input  logic                                rst,
    input  logic                                lb_wr_en,
    input  logic                                lb_rd_en,
    input  logic [vcortex_pkg::lb_addr_w-1:0]   lb_addr,
    input  logic [vcortex_pkg::lb_data_w-1:0]   lb_wr_data,
    input  logic                                frame_done,
    input  vcortex_pkg::disp_state_t            disp_state,
    output logic                                lb_wr_valid,
    output logic                                lb_rd_valid,
    output logic [vcortex_pkg::lb_data_w-1:0]   lb_rd_data,
    output logic                                disp_enable,
    output logic [vcortex_pkg::sram_addr_w-1:0] fb_base,
    output logic [vcortex_pkg::bg_w-1:0]        bg_color
);

    logic [vcortex_pkg::frm_cnt_w-1:0] frm_cnt;     // wraps
    logic                              disp_active;

    assign disp_active = (disp_state == vcortex_pkg::ST_ACTIVE) ||
                         (disp_state == vcortex_pkg::ST_DRAIN);

    //////////////////////////////////////////////////
    // write side, frame counter
    //////////////////////////////////////////////////
    always_ff @(posedge sys_clk_50)
    begin
        if (rst)
        begin
            lb_wr_valid <= 1'b0;
            disp_enable <= 1'b0;
            fb_base     <= '0;
            bg_color    <= '0;
            frm_cnt     <= '0;
        end
        else
        begin
            lb_wr_valid <= lb_wr_en;                // ack every write
            if (lb_wr_en)
            begin
                case (lb_addr)
                    vcortex_pkg::reg_ctrl: disp_enable <= lb_wr_data[0];
                    vcortex_pkg::reg_base: fb_base     <= lb_wr_data[vcortex_pkg::sram_addr_w-1:0];
                    vcortex_pkg::reg_bg:   bg_color    <= lb_wr_data[vcortex_pkg::bg_w-1:0];
                    default: ;                      // status, unmapped ignored
                endcase
            end
            if (frame_done)
                frm_cnt <= frm_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////
    always_ff @(posedge sys_clk_50)
    begin
        if (rst)
        begin
            lb_rd_valid <= 1'b0;
            lb_rd_data  <= '0;
        end
        else
        begin
            lb_rd_valid <= lb_rd_en;
            if (lb_rd_en)
            begin
                case (lb_addr)
                    vcortex_pkg::reg_ctrl:
                        lb_rd_data <= {{(vcortex_pkg::lb_data_w-1){1'b0}}, disp_enable};
                    vcortex_pkg::reg_base:
                        lb_rd_data <= {{(vcortex_pkg::lb_data_w-vcortex_pkg::sram_addr_w){1'b0}},
                                       fb_base};
                    vcortex_pkg::reg_bg:
                        lb_rd_data <= {{(vcortex_pkg::lb_data_w-vcortex_pkg::bg_w){1'b0}},
                                       bg_color};
                    vcortex_pkg::reg_status:        // count on top, active in bit 0
                        lb_rd_data <= {frm_cnt,
                                       {(vcortex_pkg::lb_data_w-vcortex_pkg::frm_cnt_w-1){1'b0}},
                                       disp_active};
                    default: lb_rd_data <= '0;      // unmapped
                endcase
            end
        end
    end

endmodule

/* sram_pixel_fetch.sv */
// sram pixel fetch
// issues one word read per visible pixel and aligns the returned colour
// with syncs and data enable through a two stage output pipeline
`timescale 1ns/1ps

module sram_pixel_fetch
(
    input  logic                                sys_clk_50,
    input  logic                                rst,
    input  logic [vcortex_pkg::h_cnt_w-1:0]     h_cnt,
    input  logic [vcortex_pkg::v_cnt_w-1:0]     v_cnt,
    input  logic                                visible,
    input  logic                                hsync_raw_n,
    input  logic                                vsync_raw_n,
    input  logic                                fetch_en,
    input  logic [vcortex_pkg::sram_addr_w-1:0] fb_base,
    input  logic [vcortex_pkg::bg_w-1:0]        bg_color,
    input  logic [vcortex_pkg::sram_data_w-1:0] sram_rd_data,
    output logic                                sram_rd_en,
    output logic [vcortex_pkg::sram_addr_w-1:0] sram_addr,
    output logic                                vga_hsync_n,
    output logic                                vga_vsync_n,
    output logic                                vga_de,
    output logic [vcortex_pkg::vga_res_w-1:0]   vga_r,
    output logic [vcortex_pkg::vga_res_w-1:0]   vga_g,
    output logic [vcortex_pkg::vga_res_w-1:0]   vga_b
);

    logic                         hs_d1, vs_d1;     // stage 1, data returns here
    logic                         vis_d1;
    logic                         fetched_d1;
    logic [vcortex_pkg::bg_w-1:0] pix_col;

    // read issued in the pixel's own cycle, word lands one cycle later
    assign sram_rd_en = visible && fetch_en;
    assign sram_addr  = fb_base +
                        vcortex_pkg::sram_addr_t'(v_cnt) * vcortex_pkg::line_stride +
                        vcortex_pkg::sram_addr_t'(h_cnt);

    always_comb
    begin
        if (fetched_d1)
            pix_col = sram_rd_data[vcortex_pkg::bg_w-1:0];
        else if (vis_d1)
            pix_col = bg_color;                     // display off
        else
            pix_col = '0;                           // blanking
    end

    //////////////////////////////////////////////////
    // output pipeline
    //////////////////////////////////////////////////
    always_ff @(posedge sys_clk_50)
    begin
        if (rst)
        begin
            hs_d1       <= 1'b1;
            vs_d1       <= 1'b1;
            vis_d1      <= 1'b0;
            fetched_d1  <= 1'b0;
            vga_hsync_n <= 1'b1;
            vga_vsync_n <= 1'b1;
            vga_de      <= 1'b0;
            vga_r       <= '0;
            vga_g       <= '0;
            vga_b       <= '0;
        end
        else
        begin
            hs_d1       <= hsync_raw_n;
            vs_d1       <= vsync_raw_n;
            vis_d1      <= visible;
            fetched_d1  <= sram_rd_en;
            vga_hsync_n <= hs_d1;
            vga_vsync_n <= vs_d1;
            vga_de      <= vis_d1;
            vga_r       <= pix_col[3*vcortex_pkg::vga_res_w-1:2*vcortex_pkg::vga_res_w];
            vga_g       <= pix_col[2*vcortex_pkg::vga_res_w-1:vcortex_pkg::vga_res_w];
            vga_b       <= pix_col[vcortex_pkg::vga_res_w-1:0];
        end
    end

endmodule

/* vcortex_top.sv */
// vcortex video controller top
// sync generator, display FSM, bus registers and sram pixel fetch
`timescale 1ns/1ps

module vcortex_top
(
    input  logic                                sys_clk_50,
    input  logic                                rst,
    input  logic                                lb_wr_en,
    input  logic                                lb_rd_en,
    input  logic [vcortex_pkg::lb_addr_w-1:0]   lb_addr,
    input  logic [vcortex_pkg::lb_data_w-1:0]   lb_wr_data,
    output logic                                lb_wr_valid,
    output logic                                lb_rd_valid,
    output logic [vcortex_pkg::lb_data_w-1:0]   lb_rd_data,
    input  logic [vcortex_pkg::sram_data_w-1:0] sram_rd_data,
    output logic                                sram_rd_en,
    output logic [vcortex_pkg::sram_addr_w-1:0] sram_addr,
    output logic                                vga_hsync_n,
    output logic                                vga_vsync_n,
    output logic                                vga_de,
    output logic [vcortex_pkg::vga_res_w-1:0]   vga_r,
    output logic [vcortex_pkg::vga_res_w-1:0]   vga_g,
    output logic [vcortex_pkg::vga_res_w-1:0]   vga_b
);

    logic [vcortex_pkg::h_cnt_w-1:0]     h_cnt;
    logic [vcortex_pkg::v_cnt_w-1:0]     v_cnt;
    logic                                hsync_raw_n, vsync_raw_n;
    logic                                visible;
    logic                                frame_start, frame_end;
    logic                                fetch_en, frame_done;
    vcortex_pkg::disp_state_t            disp_state;
    logic                                disp_enable;
    logic [vcortex_pkg::sram_addr_w-1:0] fb_base;
    logic [vcortex_pkg::bg_w-1:0]        bg_color;

    vga_sync_gen sync_gen0
    (
        .sys_clk_50 (sys_clk_50),  .rst (rst),
        .h_cnt (h_cnt),  .v_cnt (v_cnt),
        .hsync_raw_n (hsync_raw_n),  .vsync_raw_n (vsync_raw_n),
        .visible (visible),  .frame_start (frame_start),  .frame_end (frame_end)
    );

    vcortex_ctrl_fsm ctrl0
    (
        .sys_clk_50 (sys_clk_50),  .rst (rst),  .disp_enable (disp_enable),
        .frame_start (frame_start),  .frame_end (frame_end),
        .fetch_en (fetch_en),  .frame_done (frame_done),  .disp_state (disp_state)
    );

    lb_regs regs0
    (
        .sys_clk_50 (sys_clk_50),  .rst (rst),
        .lb_wr_en (lb_wr_en),  .lb_rd_en (lb_rd_en),
        .lb_addr (lb_addr),  .lb_wr_data (lb_wr_data),
        .frame_done (frame_done),  .disp_state (disp_state),
        .lb_wr_valid (lb_wr_valid),  .lb_rd_valid (lb_rd_valid),  .lb_rd_data (lb_rd_data),
        .disp_enable (disp_enable),  .fb_base (fb_base),  .bg_color (bg_color)
    );

    sram_pixel_fetch fetch0
    (
        .sys_clk_50 (sys_clk_50),  .rst (rst),
        .h_cnt (h_cnt),  .v_cnt (v_cnt),  .visible (visible),
        .hsync_raw_n (hsync_raw_n),  .vsync_raw_n (vsync_raw_n),
        .fetch_en (fetch_en),  .fb_base (fb_base),  .bg_color (bg_color),
        .sram_rd_data (sram_rd_data),  .sram_rd_en (sram_rd_en),  .sram_addr (sram_addr),
        .vga_hsync_n (vga_hsync_n),  .vga_vsync_n (vga_vsync_n),  .vga_de (vga_de),
        .vga_r (vga_r),  .vga_g (vga_g),  .vga_b (vga_b)
    );

endmodule

/* tb_sram_model.sv */
// testbench sram model
// read only, one cycle registered read, contents computed from the address
`timescale 1ns/1ps

module tb_sram_model
(
    input  logic                                sys_clk_50,
    input  logic                                rst,
    input  logic                                rd_en,
    input  logic [vcortex_pkg::sram_addr_w-1:0] addr,
    output logic [vcortex_pkg::sram_data_w-1:0] rd_data
);

    // preloaded content, word at a is a[15:0] ^ 5a5a
    always_ff @(posedge sys_clk_50)
    begin
        if (rst)
            rd_data <= '0;
        else if (rd_en)
            rd_data <= addr[15:0] ^ 16'h5A5A;       // lands one cycle after rd_en
    end

endmodule

/* vcortex_tb_top.sv */
// vcortex testbench
// bus traffic, enable sequencing and monitors for sync, data enable,
// pixel content and status frame count
`timescale 1ns/1ps

module vcortex_tb_top;

    logic        sys_clk_50 = 1'b0;
    logic        rst = 1'b1;
    logic        lb_wr_en = 1'b0, lb_rd_en = 1'b0;
    logic [11:0] lb_addr = '0;
    logic [31:0] lb_wr_data = '0, lb_rd_data, rd_word, st1, st2;
    logic        lb_wr_valid, lb_rd_valid, sram_rd_en;
    logic [15:0] sram_rd_data;
    logic [17:0] sram_addr, base_sh = '0;
    logic        vga_hsync_n, vga_vsync_n, vga_de;
    logic [3:0]  vga_r, vga_g, vga_b;
    logic [11:0] bg_sh = '0;                        // background as written
    logic        en_sh = 1'b0, mode = 1'b0;         // enable as written, frame mode
    logic        hs_q, vs_q, de_q, hs_fell;
    logic        hs_seen, vs_seen, frm_seen;
    integer      seed = 32'h9350, tmp, cycles = 0, shown1, shown2;
    int          hs_run, since_hs, vs_lines, de_lines, de_run, line, px;
    int          shown = 0, n_fetch_px = 0, n_bg_px = 0;

    always #5 sys_clk_50 = ~sys_clk_50;

    vcortex_top dut0 (.*);
    tb_sram_model sram0 (.sys_clk_50 (sys_clk_50), .rst (rst), .rd_en (sram_rd_en),
                         .addr (sram_addr), .rd_data (sram_rd_data));

    task fail_now(input string msg);
        $display("FAIL @%0t: %s", $time, msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    // expected rgb of a pixel from the frame buffer pattern
    function logic [11:0] pattern_pixel(input logic [17:0] base, input int ln, input int p);
        logic [17:0] a;
        logic [15:0] w;
        a = base + 18'(ln * vcortex_pkg::hvalid_w + p);
        w = a[15:0] ^ 16'h5A5A;
        return w[11:0];
    endfunction

    task lb_write(input logic [11:0] addr, input logic [31:0] data);
        @(posedge sys_clk_50);
        #1;
        lb_addr = addr;
        lb_wr_data = data;
        lb_wr_en = 1'b1;
        assert (!lb_wr_valid) else fail_now("write ack before strobe");
        @(posedge sys_clk_50);
        #1;
        lb_wr_en = 1'b0;
        assert (lb_wr_valid) else fail_now("write ack missing one cycle after strobe");
    endtask

    task lb_read(input logic [11:0] addr, output logic [31:0] data);
        @(posedge sys_clk_50);
        #1;
        lb_addr = addr;
        lb_rd_en = 1'b1;
        assert (!lb_rd_valid) else fail_now("read valid before strobe");
        @(posedge sys_clk_50);
        #1;
        lb_rd_en = 1'b0;
        assert (lb_rd_valid) else fail_now("read valid missing one cycle after strobe");
        data = lb_rd_data;
    endtask

    task wait_vsync_fall;                           // monitor vars read on negedge
        logic last;
        @(negedge sys_clk_50);
        last = vga_vsync_n;
        forever
        begin
            @(negedge sys_clk_50);
            if (last && !vga_vsync_n)
                break;
            last = vga_vsync_n;
        end
    endtask

    //////////////////////////////////////////////////
    // sync, data enable and pixel monitors
    //////////////////////////////////////////////////
    always @(posedge sys_clk_50)
    begin
        if (rst)
        begin
            hs_q = 1'b1;
            vs_q = 1'b1;
            de_q = 1'b0;
            hs_seen = 1'b0;
            vs_seen = 1'b0;
            frm_seen = 1'b0;
            hs_run = 0;
            since_hs = 0;
            vs_lines = 0;
            de_lines = 0;
            de_run = 0;
            line = 0;
            px = 0;
        end
        else
        begin
            if (vga_hsync_n != hs_q)                // previous level just ended
            begin
                if (hs_seen)
                    assert (hs_run == (hs_q ? vcortex_pkg::hbp_w + vcortex_pkg::hvalid_w +
                                             vcortex_pkg::hfp_w : vcortex_pkg::hsync_w))
                    else fail_now($sformatf("hsync level %0b lasted %0d", hs_q, hs_run));
                hs_seen = 1'b1;
                hs_run = 1;
            end
            else
                hs_run++;
            since_hs = (!hs_q && vga_hsync_n) ? 0 : since_hs + 1;
            hs_fell = hs_q && !vga_hsync_n;
            if (vga_vsync_n != vs_q)                // vsync widths in lines
            begin
                if (vs_seen)
                    assert (vs_lines == (vs_q ? vcortex_pkg::vbp_w + vcortex_pkg::vvalid_w +
                                               vcortex_pkg::vfp_w : vcortex_pkg::vsync_w))
                    else fail_now($sformatf("vsync level %0b lasted %0d lines", vs_q, vs_lines));
                vs_seen = 1'b1;
                vs_lines = 0;
            end
            if (hs_fell)
                vs_lines++;
            if (vs_q && !vga_vsync_n)               // new frame numbering
            begin
                if (frm_seen)
                    assert (de_lines == vcortex_pkg::vvalid_w)
                    else fail_now($sformatf("%0d active lines in frame", de_lines));
                frm_seen = 1'b1;
                de_lines = 0;
                line = 0;
            end
            if (vga_de && !de_q)
            begin
                assert (since_hs == vcortex_pkg::hbp_w)
                else fail_now($sformatf("de rose %0d clocks after hsync", since_hs));
                de_lines++;
                de_run = 0;
                if (line == 0)                      // frame mode latched at first pixel
                begin
                    if (mode)
                        shown++;
                    mode = en_sh;
                end
            end
            if (vga_de)
            begin
                if (mode)
                begin
                    assert ({vga_r, vga_g, vga_b} == pattern_pixel(base_sh, line, px))
                    else fail_now($sformatf("pixel (%0d,%0d) not from sram", line, px));
                    n_fetch_px++;
                end
                else
                begin
                    assert ({vga_r, vga_g, vga_b} == bg_sh)
                    else fail_now($sformatf("pixel (%0d,%0d) not background", line, px));
                    n_bg_px++;
                end
                px++;
                de_run++;
            end
            if (!vga_de && de_q)
            begin
                assert (de_run == vcortex_pkg::hvalid_w)
                else fail_now($sformatf("de high for %0d clocks", de_run));
                line++;
                px = 0;
            end
            hs_q = vga_hsync_n;
            vs_q = vga_vsync_n;
            de_q = vga_de;
        end
    end

    // about ten frames of traffic in all
    always @(posedge sys_clk_50)
    begin
        cycles++;
        if (cycles >= 4000)
        begin
            $display("timeout: run did not finish within 4000 cycles");
            $display("Test failures found");
            $fatal(1);
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    initial
    begin
        repeat (2) @(posedge sys_clk_50);
        #1 rst = 1'b0;
        wait_vsync_fall();                          // all writes land in blanking
        tmp = $random(seed);
        lb_write(vcortex_pkg::reg_base, tmp);
        base_sh = tmp[17:0];
        tmp = $random(seed);
        lb_write(vcortex_pkg::reg_bg, tmp);
        bg_sh = tmp[11:0];
        lb_write(12'h020, 32'hFFFF_FFFF);           // unmapped address is ignored
        lb_read(vcortex_pkg::reg_base, rd_word);
        assert (rd_word == {14'h0, base_sh}) else fail_now("base readback mismatch");
        lb_read(vcortex_pkg::reg_bg, rd_word);
        assert (rd_word == {20'h0, bg_sh}) else fail_now("background readback mismatch");
        lb_read(12'h010, rd_word);
        assert (rd_word == 32'h0) else fail_now("unmapped read not zero");
        repeat (2) wait_vsync_fall();               // one whole background frame
        lb_write(vcortex_pkg::reg_ctrl, 32'h1);
        en_sh = 1'b1;
        repeat (2) wait_vsync_fall();
        lb_read(vcortex_pkg::reg_status, st1);
        shown1 = shown;
        assert (st1[0]) else fail_now("status not active while displaying");
        repeat (2) wait_vsync_fall();
        lb_read(vcortex_pkg::reg_status, st2);
        shown2 = shown;
        assert (st2[0]) else fail_now("status not active while displaying");
        assert (32'(st2[31:16] - st1[31:16]) == shown2 - shown1)
        else fail_now($sformatf("frame count moved %0d, frames shown %0d",
                                st2[31:16] - st1[31:16], shown2 - shown1));
        wait_vsync_fall();
        while (line != 0)                           // monitor restarts line count
            @(negedge sys_clk_50);
        while (line < 3)                            // clear mid frame
            @(negedge sys_clk_50);
        lb_write(vcortex_pkg::reg_ctrl, 32'h0);
        en_sh = 1'b0;
        repeat (2) wait_vsync_fall();               // drained frame then background
        assert (n_fetch_px > 0 && n_bg_px > 0) else fail_now("pixel checks never reached");
        $display("All tests passed!");
        $finish;
    end

endmodule

/* verilog.f */
vcortex_pkg.sv
vga_sync_gen.sv
vcortex_ctrl_fsm.sv
lb_regs.sv
sram_pixel_fetch.sv
vcortex_top.sv
tb_sram_model.sv
vcortex_tb_top.sv

/* Makefile */
# Verilator build and run for the vcortex testbench

VERILATOR ?= verilator
TOP       ?= vcortex_tb_top
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed!

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
